// ==== Makefile ====
# Verilator build and run for the race video testbench

SIM := obj_dir/Vrace_tb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): compile.f $(wildcard hw/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing -Wno-fatal -f compile.f --top-module race_tb

# pass only if the testbench printed its pass line
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
hw/race_pkg.sv
hw/raster_timing.sv
hw/game_regs.sv
hw/sprite_scheduler.sv
hw/sprite_renderer.sv
hw/playfield_mixer.sv
hw/race_video_top.sv
dv/race_tb.sv

// ==== dv/race_tb.sv ====
`timescale 1ns/1ns

module race_tb;

  localparam int frames     = 6;    // full frames after reset
  localparam int setup_line = 250;  // vblank line where the next frame gets set up
  // twice the nominal run at 8 ns per pixel
  localparam longint timeout_ns = longint'(frames) * longint'(race_pkg::v_total) *
                                  longint'(race_pkg::h_total) * 8 * 2;

  logic       clk2;
  logic       rst_n;
  logic       wr_en;
  logic [3:0] wr_addr;
  logic [7:0] wr_data;
  logic [7:0] rd_addr;
  logic [7:0] rd_data;
  logic       hsync;
  logic       vsync;
  logic       display_on;
  logic [8:0] hpos;
  logic [8:0] vpos;
  logic [2:0] rgb;

  // reference model of the state the dut shows at the next falling edge
  logic [8:0]  m_hpos;
  logic [8:0]  m_vpos;
  logic        m_coll;
  logic [7:0]  shadow [0:15];  // copy of the register file
  logic [11:0] pending [$];    // {addr, data} writes queued for vblank
  int frames_done;
  int setup_count;   // picks the frame scenario

  race_video_top dut_i (
    .clk2(clk2), .rst_n(rst_n), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_addr(rd_addr), .rd_data(rd_data), .hsync(hsync), .vsync(vsync),
    .display_on(display_on), .hpos(hpos), .vpos(vpos), .rgb(rgb)
  );

  always #4 clk2 = ~clk2;  // 8 ns period

  function automatic logic hsync_window();
    return (m_hpos >= race_pkg::hsync_start) && (m_hpos <= race_pkg::hsync_end);
  endfunction

  function automatic logic vsync_window();
    return (m_vpos >= race_pkg::vsync_start) && (m_vpos <= race_pkg::vsync_end);
  endfunction

  function automatic logic visible_area();
    return (m_hpos < race_pkg::h_display) && (m_vpos < race_pkg::v_display);
  endfunction

  // car i covers x+1..x+8 and y+1..y+16 with the msb leftmost
  function automatic logic sprite_pixel(input int i);
    int dx;
    int dy;
    logic [7:0] row_bits;
    dx = int'(m_hpos) - int'(shadow[race_pkg::reg_sprite_base + 2 * i]) - 1;
    dy = int'(m_vpos) - int'(shadow[race_pkg::reg_sprite_base + 2 * i + 1]) - 1;
    if (dx < 0 || dx >= race_pkg::sprite_w || dy < 0 || dy >= race_pkg::sprite_h) begin
      return 1'b0;
    end
    row_bits = race_pkg::car_bitmap[dy];
    return row_bits[7 - dx];
  endfunction

  function automatic logic enemy_pixel();
    logic any;
    any = 1'b0;
    for (int i = 1; i < race_pkg::num_sprites; i++) begin
      any = any | sprite_pixel(i);
    end
    return any;
  endfunction

  // grass stripes scroll with the track byte
  function automatic logic on_track();
    logic [7:0] tp;
    logic offside;
    tp = shadow[race_pkg::reg_trackpos];
    offside = (m_hpos[7:5] == 3'd0) || (m_hpos[7:5] == 3'd7);
    return offside && (m_vpos[5:1] != tp[5:1]);
  endfunction

  function automatic logic [2:0] pixel_colour();
    logic on;
    logic shoulder;
    logic magenta;
    logic green;
    on       = visible_area();
    shoulder = (m_hpos[7:3] == 5'd3) || (m_hpos[7:3] == 5'd28);
    magenta  = enemy_pixel() || shoulder;   // red and blue together
    green    = sprite_pixel(0) || on_track();
    return {on && magenta, on && green, on && magenta};
  endfunction

  function automatic logic [7:0] read_value(input logic [7:0] a);
    logic [7:0] v;
    v = 8'h00;  // unmapped
    if (a[7:4] == 4'h0) begin
      v = shadow[a[3:0]];
    end else if (a == race_pkg::rd_hpos) begin
      v = m_hpos[7:0];
    end else if (a == race_pkg::rd_vpos) begin
      v = m_vpos[7:0];
    end else if (a == race_pkg::rd_flags) begin
      v = {2'b00, m_coll, vsync_window(), hsync_window(), 2'b00, visible_area()};
    end
    return v;
  endfunction

  task automatic reset_model();
    m_hpos = 9'd0;
    m_vpos = 9'd0;
    m_coll = 1'b0;
    for (int a = 0; a < 16; a++) begin
      shadow[a] = 8'h00;
    end
  endtask

  // one clock edge with the inputs just driven
  task automatic advance_model(input logic run);
    logic player;
    logic hit;
    if (!run) begin
      reset_model();
    end else begin
      player = sprite_pixel(0);
      hit    = enemy_pixel() || on_track();
      if (player && hit) begin
        m_coll = 1'b1;            // set beats the frame clear
      end else if (m_vpos == 9'd0) begin
        m_coll = 1'b0;
      end
      if (wr_en) shadow[wr_addr] = wr_data;
      if (m_hpos == race_pkg::h_total - 9'd1) begin
        m_hpos = 9'd0;
        if (m_vpos == race_pkg::v_total - 9'd1) begin
          m_vpos = 9'd0;
          frames_done++;
        end else begin
          m_vpos = m_vpos + 9'd1;
        end
      end else begin
        m_hpos = m_hpos + 9'd1;
      end
    end
  endtask

  task automatic report_mismatch(input string sig, input logic [8:0] got,
                                 input logic [8:0] exp);
    $display("mismatch at %0t ns: %s is %h, expected %h", $time, sig, got, exp);
    $display("Done: errors found");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_raster(input logic [8:0] h, input logic [8:0] v,
                              input logic hs, input logic vs, input logic de);
    if (h !== m_hpos) report_mismatch("hpos", h, m_hpos);
    if (v !== m_vpos) report_mismatch("vpos", v, m_vpos);
    if (hs !== hsync_window()) report_mismatch("hsync", {8'h00, hs}, {8'h00, hsync_window()});
    if (vs !== vsync_window()) report_mismatch("vsync", {8'h00, vs}, {8'h00, vsync_window()});
    if (de !== visible_area()) begin
      report_mismatch("display_on", {8'h00, de}, {8'h00, visible_area()});
    end
  endtask

  task automatic check_rgb(input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) report_mismatch("rgb", {6'h00, got}, {6'h00, exp});
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) report_mismatch("rd_data", {1'b0, got}, {1'b0, exp});
  endtask

  // coordinates kept inside the visible area
  function automatic logic [7:0] legal_value(input logic [3:0] a, input logic [7:0] raw);
    int slot;
    slot = int'(a) - race_pkg::reg_sprite_base;
    if (slot < 0 || slot >= 2 * race_pkg::num_sprites) return raw;
    if (slot % 2 == 0) return 8'(raw % 241);  // x in 0..240
    return 8'(1 + raw % 220);                 // y in 1..220
  endfunction

  function automatic logic [7:0] pick_read_addr();
    logic [7:0] a;
    case ($urandom_range(0, 3))
      0: a = {4'h0, 4'($urandom_range(0, 15))};
      1: a = race_pkg::rd_flags;
      2: a = ($urandom_range(0, 1) == 0) ? race_pkg::rd_hpos : race_pkg::rd_vpos;
      default: a = 8'($urandom);  // mostly unmapped
    endcase
    return a;
  endfunction

  // clean road then pile-up then grass
  task automatic queue_frame_setup();
    int px;
    int py;
    int ex;
    int ey;
    int base;
    case (setup_count % 3)
      0: begin
        px = int'($urandom_range(40, 200));   // stays off the grass
        py = int'($urandom_range(1, 220));
      end
      1: begin
        px = int'($urandom_range(0, 236));
        py = int'($urandom_range(1, 216));
      end
      default: begin
        px = int'($urandom_range(0, 20));     // left grass
        py = int'($urandom_range(1, 220));
      end
    endcase
    base = race_pkg::reg_sprite_base;
    pending.push_back({4'(base), 8'(px)});
    pending.push_back({4'(base + 1), 8'(py)});
    for (int i = 1; i < race_pkg::num_sprites; i++) begin
      ex = int'($urandom_range(0, 240));
      ey = int'($urandom_range(1, 220));
      if (setup_count % 3 == 0) begin
        // at least 20 lines away so the cars never touch
        if (py > 110) ey = py - int'($urandom_range(20, 100));
        else ey = py + int'($urandom_range(20, 100));
      end else if (setup_count % 3 == 1) begin
        ex = px + int'($urandom_range(0, 4));
        ey = py + int'($urandom_range(0, 4));
      end
      pending.push_back({4'(base + 2 * i), 8'(ex)});
      pending.push_back({4'(base + 2 * i + 1), 8'(ey)});
    end
    pending.push_back({4'(race_pkg::reg_trackpos), 8'($urandom)});
    setup_count++;
  endtask

  // writes only in vblank
  task automatic drive_inputs();
    logic [11:0] next_wr;
    logic        blank;
    wr_en = 1'b0;
    blank = (m_vpos >= race_pkg::v_display);
    if (m_vpos == 9'(setup_line) && m_hpos == 9'd0) queue_frame_setup();
    if (blank && pending.size() > 0) begin
      next_wr = pending.pop_front();
      wr_addr = next_wr[11:8];
      wr_data = next_wr[7:0];
      wr_en   = 1'b1;
    end else if (blank && m_vpos < 9'(setup_line) && $urandom_range(0, 7) == 0) begin
      wr_addr = 4'($urandom_range(0, 15));
      wr_data = legal_value(wr_addr, 8'($urandom));
      wr_en   = 1'b1;
    end
    if (wr_en) rd_addr = {4'h0, wr_addr};  // read it back next cycle
    else rd_addr = pick_read_addr();
  endtask

  task automatic check_outputs();
    check_raster(hpos, vpos, hsync, vsync, display_on);
    check_rgb(rgb, pixel_colour());
    check_byte(rd_data, read_value(rd_addr));
  endtask

  initial begin
    #(timeout_ns);
    $display("simulation timed out before all frames were drawn");
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(20));
    clk2    = 1'b0;
    rst_n   = 1'b0;
    wr_en   = 1'b0;
    wr_addr = 4'h0;
    wr_data = 8'h00;
    rd_addr = 8'h00;
    frames_done = 0;
    setup_count = 0;
    reset_model();

    // outputs checked on each of the 4 reset edges
    for (int c = 0; c < 4; c++) begin
      @(negedge clk2);
      check_outputs();
      case (c)
        0: rd_addr = race_pkg::rd_hpos;
        1: rd_addr = race_pkg::rd_vpos;
        default: rd_addr = race_pkg::rd_flags;
      endcase
      rst_n = (c == 3);  // released before the 5th edge
      advance_model(rst_n);
    end

    while (frames_done < frames) begin
      @(negedge clk2);
      check_outputs();
      drive_inputs();
      advance_model(1'b1);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== hw/game_regs.sv ====
`timescale 1ns/1ns

module game_regs (
  input  logic       clk2,
  input  logic       rst_n,
  // write strobe from the cpu side
  input  logic       wr_en,
  input  logic [3:0] wr_addr,
  input  logic [7:0] wr_data,
  // combinational read port
  input  logic [7:0] rd_addr,
  output logic [7:0] rd_data,
  // live status for the special read addresses
  input  logic [8:0] hpos,
  input  logic [8:0] vpos,
  input  logic       hsync,
  input  logic       vsync,
  input  logic       display_on,
  input  logic       collision,
  // parallel views of the game state
  output logic [race_pkg::num_sprites-1:0][7:0] sprite_x,
  output logic [race_pkg::num_sprites-1:0][7:0] sprite_y,
  output logic [7:0] trackpos
);

  logic [7:0] ram [0:15];  // 16 game bytes
  logic [7:0] flags;

  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      for (int a = 0; a < 16; a++) begin
        ram[a] <= 8'h00;
      end
    end else if (wr_en) begin
      ram[wr_addr] <= wr_data;
    end
  end

  // {0, 0, collision, vsync, hsync, 0, 0, display_on}
  assign flags = {2'b00, collision, vsync, hsync, 2'b00, display_on};

  always_comb begin
    rd_data = 8'h00;                     // unmapped reads as zero
    if (rd_addr[7:4] == 4'h0) begin
      rd_data = ram[rd_addr[3:0]];
    end else if (rd_addr == race_pkg::rd_hpos) begin
      rd_data = hpos[7:0];               // low byte only
    end else if (rd_addr == race_pkg::rd_vpos) begin
      rd_data = vpos[7:0];
    end else if (rd_addr == race_pkg::rd_flags) begin
      rd_data = flags;
    end
  end

  // sprite coordinate pairs
  always_comb begin
    for (int i = 0; i < race_pkg::num_sprites; i++) begin
      sprite_x[i] = ram[race_pkg::reg_sprite_base + 2 * i];
      sprite_y[i] = ram[race_pkg::reg_sprite_base + 2 * i + 1];
    end
  end

  assign trackpos = ram[race_pkg::reg_trackpos];  // scroll position byte

endmodule

// ==== hw/playfield_mixer.sv ====
`timescale 1ns/1ns

module playfield_mixer (
  input  logic       clk2,
  input  logic       rst_n,
  input  logic [8:0] hpos,
  input  logic [8:0] vpos,
  input  logic       display_on,
  input  logic [7:0] trackpos,
  input  logic [race_pkg::num_sprites-1:0] gfx,  // bit 0 is the player
  output logic       collision,
  output logic [2:0] rgb                          // {r, g, b}
);

  logic player_gfx;
  logic enemy_gfx;
  logic offside;
  logic shoulder;
  logic track_gfx;

  assign player_gfx = gfx[0];
  assign enemy_gfx  = |gfx[race_pkg::num_sprites-1:1];  // any enemy car

  // grass on both sides of the road
  assign offside  = (hpos[7:5] == 3'd0) || (hpos[7:5] == 3'd7);
  // road edge stripes, 8 pixels wide
  assign shoulder = (hpos[7:3] == 5'd3) || (hpos[7:3] == 5'd28);
  // scrolling stripes on the grass
  assign track_gfx = offside && (vpos[5:1] != trackpos[5:1]);

  // per-frame collision latch
  // set wins over the vpos 0 clear
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      collision <= 1'b0;
    end else if (player_gfx && (enemy_gfx || track_gfx)) begin
      collision <= 1'b1;
    end else if (vpos == 9'd0) begin
      collision <= 1'b0;  // new frame
    end
  end

  // colour, blanked outside the visible area
  always_comb begin
    rgb[2] = display_on && (enemy_gfx || shoulder);   // red
    rgb[1] = display_on && (player_gfx || track_gfx); // green
    rgb[0] = display_on && (enemy_gfx || shoulder);   // blue
  end

endmodule

// ==== hw/race_pkg.sv ====
package race_pkg;

  // raster geometry, 9-bit counters
  localparam logic [8:0] h_display = 9'd256; // visible columns
  localparam logic [8:0] h_total   = 9'd320; // columns per line incl. hblank
  localparam logic [8:0] v_display = 9'd240; // visible lines
  localparam logic [8:0] v_total   = 9'd262; // lines per frame

  // sync windows, inclusive at both ends
  localparam logic [8:0] hsync_start = 9'd280;
  localparam logic [8:0] hsync_end   = 9'd295;
  localparam logic [8:0] vsync_start = 9'd245;
  localparam logic [8:0] vsync_end   = 9'd247;

  // sprite setup. sprite 0 is the player, the rest are enemies
  localparam int num_sprites = 2;
  localparam int slot_len    = 4;  // hblank clocks per fetch slot
  localparam int sprite_w    = 8;
  localparam int sprite_h    = 16;

  // game register map
  localparam int reg_sprite_base = 2; // x at base+2i, y at base+2i+1
  localparam int reg_trackpos    = 8;

  // special read addresses
  localparam logic [7:0] rd_hpos  = 8'h40;
  localparam logic [7:0] rd_vpos  = 8'h41;
  localparam logic [7:0] rd_flags = 8'h42;

  // renderer states
  localparam logic [1:0] st_idle       = 2'd0; // waiting for vstart
  localparam logic [1:0] st_wait_load  = 2'd1; // waiting for own fetch slot
  localparam logic [1:0] st_wait_hstart = 2'd2;
  localparam logic [1:0] st_draw       = 2'd3;

  // car seen from above, msb is leftmost pixel
  localparam logic [7:0] car_bitmap [0:15] = '{
    8'b00111100,  // front bumper
    8'b00111100,
    8'b11111111,  // front wheels
    8'b11111111,
    8'b11011011,
    8'b00111100,
    8'b00100100,  // cockpit
    8'b00111100,
    8'b00111100,
    8'b00100100,
    8'b00111100,
    8'b11011011,
    8'b11111111,  // rear wheels
    8'b11111111,
    8'b00111100,
    8'b00011000   // exhaust
  };

endpackage

// ==== hw/race_video_top.sv ====
`timescale 1ns/1ns

module race_video_top (
  input  logic       clk2,
  input  logic       rst_n,
  input  logic       wr_en,
  input  logic [3:0] wr_addr,
  input  logic [7:0] wr_data,
  input  logic [7:0] rd_addr,
  output logic [7:0] rd_data,
  output logic       hsync,
  output logic       vsync,
  output logic       display_on,
  output logic [8:0] hpos,
  output logic [8:0] vpos,
  output logic [2:0] rgb
);

  logic [race_pkg::num_sprites-1:0][7:0] sprite_x;
  logic [race_pkg::num_sprites-1:0][7:0] sprite_y;
  logic [race_pkg::num_sprites-1:0][3:0] rom_row;
  logic [race_pkg::num_sprites-1:0]      vstart;
  logic [race_pkg::num_sprites-1:0]      hstart;
  logic [race_pkg::num_sprites-1:0]      load;
  logic [race_pkg::num_sprites-1:0]      gfx;
  logic [7:0] rom_bits;   // shared bitmap row
  logic [7:0] trackpos;
  logic       collision;

  raster_timing raster_i (
    .clk2(clk2), .rst_n(rst_n), .hpos(hpos), .vpos(vpos),
    .hsync(hsync), .vsync(vsync), .display_on(display_on)
  );

  game_regs regs_i (
    .clk2(clk2), .rst_n(rst_n),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_addr(rd_addr), .rd_data(rd_data),
    .hpos(hpos), .vpos(vpos), .hsync(hsync), .vsync(vsync),
    .display_on(display_on), .collision(collision),
    .sprite_x(sprite_x), .sprite_y(sprite_y), .trackpos(trackpos)
  );

  sprite_scheduler sched_i (
    .hpos(hpos), .vpos(vpos), .sprite_x(sprite_x), .sprite_y(sprite_y),
    .rom_row(rom_row), .vstart(vstart), .hstart(hstart), .load(load),
    .rom_bits(rom_bits)
  );

  // one renderer per car, sprite 0 is the player
  for (genvar i = 0; i < race_pkg::num_sprites; i++) begin : g_car
    sprite_renderer car_i (
      .clk2(clk2), .rst_n(rst_n),
      .vstart(vstart[i]), .hstart(hstart[i]), .load(load[i]),
      .rom_bits(rom_bits), .rom_row(rom_row[i]), .gfx(gfx[i])
    );
  end

  playfield_mixer mixer_i (
    .clk2(clk2), .rst_n(rst_n), .hpos(hpos), .vpos(vpos),
    .display_on(display_on), .trackpos(trackpos), .gfx(gfx),
    .collision(collision), .rgb(rgb)
  );

endmodule

// ==== hw/raster_timing.sv ====
`timescale 1ns/1ns

module raster_timing (
  input  logic       clk2,
  input  logic       rst_n,
  output logic [8:0] hpos,
  output logic [8:0] vpos,
  output logic       hsync,
  output logic       vsync,
  output logic       display_on
);

  logic       h_wrap;  // last column of the line
  logic       v_wrap;  // last line of the frame
  logic [8:0] h_next;
  logic [8:0] v_next;

  assign h_wrap = (hpos == race_pkg::h_total - 9'd1);
  assign v_wrap = (vpos == race_pkg::v_total - 9'd1);

  // next counter values, also used for the sync registers
  assign h_next = h_wrap ? 9'd0 : hpos + 9'd1;

  always_comb begin
    v_next = vpos;            // holds until end of line
    if (h_wrap) begin
      v_next = v_wrap ? 9'd0 : vpos + 9'd1;
    end
  end

  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      hpos  <= 9'd0;
      vpos  <= 9'd0;
      hsync <= 1'b0;
      vsync <= 1'b0;
    end else begin
      hpos <= h_next;
      vpos <= v_next;
      // sync compared on next position so it lines up with hpos/vpos
      hsync <= (h_next >= race_pkg::hsync_start) && (h_next <= race_pkg::hsync_end);
      vsync <= (v_next >= race_pkg::vsync_start) && (v_next <= race_pkg::vsync_end);
    end
  end

  // visible area
  assign display_on = (hpos < race_pkg::h_display) && (vpos < race_pkg::v_display);

endmodule

// ==== hw/sprite_renderer.sv ====
`timescale 1ns/1ns

module sprite_renderer (
  input  logic       clk2,
  input  logic       rst_n,
  input  logic       vstart,
  input  logic       hstart,
  input  logic       load,
  input  logic [7:0] rom_bits,
  output logic [3:0] rom_row,
  output logic       gfx
);

  logic [1:0] state;
  logic [3:0] row;       // current bitmap row
  logic [2:0] xcount;    // bit being emitted
  logic [7:0] outbits;   // row shifter, msb out first

  assign rom_row = row;  // scheduler looks it up during our slot

  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      state   <= race_pkg::st_idle;
      row     <= 4'd0;
      xcount  <= 3'd0;
      outbits <= 8'h00;
      gfx     <= 1'b0;
    end else begin
      case (state)
        race_pkg::st_idle: begin
          gfx <= 1'b0;
          row <= 4'd0;
          if (vstart) state <= race_pkg::st_wait_load;  // top line reached
        end
        race_pkg::st_wait_load: begin
          gfx <= 1'b0;
          if (load) begin
            outbits <= rom_bits;  // first clock of the slot
            state   <= race_pkg::st_wait_hstart;
          end
        end
        race_pkg::st_wait_hstart: begin
          gfx <= 1'b0;
          if (hstart) begin
            // bit 0 already goes out here, shows at x+1
            gfx     <= outbits[7];
            outbits <= {outbits[6:0], 1'b0};
            xcount  <= 3'd1;
            state   <= race_pkg::st_draw;
          end
        end
        race_pkg::st_draw: begin
          gfx     <= outbits[7];
          outbits <= {outbits[6:0], 1'b0};
          xcount  <= xcount + 3'd1;
          if (xcount == 3'(race_pkg::sprite_w - 1)) begin
            // last pixel of the row
            if (row == 4'(race_pkg::sprite_h - 1)) begin
              state <= race_pkg::st_idle;
            end else begin
              row   <= row + 4'd1;
              state <= race_pkg::st_wait_load;  // next row fetched this line
            end
          end
        end
        default: state <= race_pkg::st_idle;
      endcase
    end
  end

endmodule

// ==== hw/sprite_scheduler.sv ====
`timescale 1ns/1ns

module sprite_scheduler (
  input  logic [8:0] hpos,
  input  logic [8:0] vpos,
  input  logic [race_pkg::num_sprites-1:0][7:0] sprite_x,
  input  logic [race_pkg::num_sprites-1:0][7:0] sprite_y,
  // row address requested by each renderer
  input  logic [race_pkg::num_sprites-1:0][3:0] rom_row,
  output logic [race_pkg::num_sprites-1:0]      vstart,
  output logic [race_pkg::num_sprites-1:0]      hstart,
  output logic [race_pkg::num_sprites-1:0]      load,
  // shared bitmap row, valid for the sprite whose slot is active
  output logic [7:0] rom_bits
);

  logic [3:0] sel_row;  // row address of the slot owner

  // start strobes, level while raster sits on the coordinate
  always_comb begin
    for (int i = 0; i < race_pkg::num_sprites; i++) begin
      vstart[i] = ({1'b0, sprite_y[i]} == vpos);
      hstart[i] = ({1'b0, sprite_x[i]} == hpos);
    end
  end

  // hblank split into fixed slots
  // sprite i owns h_display + slot_len*i .. + slot_len - 1
  always_comb begin
    load    = '0;
    sel_row = 4'd0;
    for (int i = 0; i < race_pkg::num_sprites; i++) begin
      if ((hpos >= race_pkg::h_display + 9'(race_pkg::slot_len * i)) &&
          (hpos <  race_pkg::h_display + 9'(race_pkg::slot_len * (i + 1)))) begin
        load[i] = 1'b1;
        sel_row = rom_row[i];  // slots never overlap, so one owner
      end
    end
  end

  // one car bitmap for everybody
  assign rom_bits = race_pkg::car_bitmap[sel_row];

endmodule
